//--- common/cpuPkg.sv
// ------------------------------------------------
// Types and ISA constants of the 5-stage core.
// An instruction word is op, func, rd, rs1, imm16.
// rs2 overlaps the top nibble of the immediate.
// ------------------------------------------------
package cpuPkg;

	localparam int xlen = 32;
	localparam int regIdxBits = 4;
	localparam int fieldBits = 4;
	localparam int immBits = 16;

	// Field positions inside the instruction word
	localparam int opLsb = 28;
	localparam int funcLsb = 24;
	localparam int rdLsb = 20;
	localparam int rs1Lsb = 16;
	localparam int rs2Lsb = 12;

	typedef logic [regIdxBits-1:0] regIdxT;

	// Major opcodes; every other value is a no-op
	typedef enum logic [fieldBits-1:0] {
		opLw   = 4'h3,
		opAluI = 4'h4,
		opSw   = 4'h7,
		opAluR = 4'hC,
		opCmpR = 4'hD
	} opcodeT;

	// ALU and ALU-I func field uses these codes directly.
	// CMPR func field: eq 1, lt 2, ne 9, ge A. Bit 3 negates,
	// bit 1 picks lt over eq, so decode folds it onto fnEq..fnGe
	typedef enum logic [fieldBits-1:0] {
		fnAdd = 4'h0,
		fnSub = 4'h1,
		fnAnd = 4'h4,
		fnOr  = 4'h5,
		fnXor = 4'h6,
		fnEq  = 4'h8,
		fnLt  = 4'h9,
		fnNe  = 4'hA,
		fnGe  = 4'hB
	} aluFuncT;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] word;
	} instInT;

	typedef struct packed {
		logic            valid;
		aluFuncT         aluFunc;
		logic            useImm;
		logic            wrReg;
		logic            isLoad;
		logic            isStore;
		regIdxT          rd;
		regIdxT          rs1;
		regIdxT          rs2;
		logic [xlen-1:0] rs1Data;
		logic [xlen-1:0] rs2Data;
		logic [xlen-1:0] immediate;
	} decExT;

	typedef struct packed {
		logic            valid;
		logic            wrReg;
		logic            isLoad;
		logic            isStore;
		regIdxT          rd;
		logic [xlen-1:0] aluResult;
		logic [xlen-1:0] storeData;
	} exMemT;

	// Write-back payload, also the retire port
	typedef struct packed {
		logic            valid;
		logic            wrReg;
		regIdxT          rd;
		logic [xlen-1:0] data;
	} retireT;

endpackage

//--- src/registerFile.sv
// ------------------------------------------------
// 16 x 32 register file, two read ports.
// Same-cycle write is visible on the read ports.
// ------------------------------------------------
`timescale 1ns/1ps

module registerFile
	import cpuPkg::*;
(
	input  logic            clk,
	input  logic            rstN,
	input  regIdxT          rdIdx1,
	input  regIdxT          rdIdx2,
	output logic [xlen-1:0] rdData1,
	output logic [xlen-1:0] rdData2,
	input  retireT          wbIn
);

	logic [xlen-1:0] regs [2**regIdxBits];
	logic            wrEn;

	assign wrEn = wbIn.valid && wbIn.wrReg;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**regIdxBits; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wbIn.rd] <= wbIn.data;
		end
	end

	// Write-through covers the three-ahead producer
	assign rdData1 = (wrEn && wbIn.rd == rdIdx1) ? wbIn.data : regs[rdIdx1];
	assign rdData2 = (wrEn && wbIn.rd == rdIdx2) ? wbIn.data : regs[rdIdx2];

	wbIdxKnown: assert property (@(posedge clk) disable iff (!rstN)
		wrEn |-> !$isunknown(wbIn.rd));

endmodule

//--- src/decodeStage.sv
// ------------------------------------------------
// Fetch register plus decode and register read.
// Stores name their data register in rd.
// Unknown opcodes pass as no-ops that still retire.
// ------------------------------------------------
`timescale 1ns/1ps

module decodeStage
	import cpuPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  instInT instIn,
	input  retireT wbIn,
	output decExT  decEx
);

	instInT                 fetchQ;
	opcodeT                 op;
	logic [fieldBits-1:0]   funcField;
	regIdxT                 rdIdx;
	regIdxT                 rs1Idx;
	regIdxT                 readIdx2;
	logic [immBits-1:0]     imm;
	logic [xlen-1:0]        rdData1;
	logic [xlen-1:0]        rdData2;
	decExT                  decNext;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fetchQ <= '0;
		end else begin
			fetchQ <= instIn;
		end
	end

	assign op        = opcodeT'(fetchQ.word[opLsb +: fieldBits]);
	assign funcField = fetchQ.word[funcLsb +: fieldBits];
	assign rdIdx     = fetchQ.word[rdLsb +: regIdxBits];
	assign rs1Idx    = fetchQ.word[rs1Lsb +: regIdxBits];
	assign imm       = fetchQ.word[immBits-1:0];

	// Second port reads the store data register for SW
	assign readIdx2 = (op == opSw) ? rdIdx : fetchQ.word[rs2Lsb +: regIdxBits];

	registerFile registerFile (
		.clk    (clk),
		.rstN   (rstN),
		.rdIdx1 (rs1Idx),
		.rdIdx2 (readIdx2),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.wbIn   (wbIn)
	);

	always_comb begin
		decNext           = '0;
		decNext.valid     = fetchQ.valid;
		decNext.aluFunc   = aluFuncT'(funcField);
		decNext.rd        = rdIdx;
		decNext.rs1       = rs1Idx;
		decNext.rs2       = readIdx2;
		decNext.rs1Data   = rdData1;
		decNext.rs2Data   = rdData2;
		decNext.immediate = {{(xlen-immBits){imm[immBits-1]}}, imm};
		case (op)
			opAluR: decNext.wrReg = 1'b1;
			opAluI: begin
				decNext.wrReg  = 1'b1;
				decNext.useImm = 1'b1;
			end
			opCmpR: begin
				decNext.wrReg   = 1'b1;
				decNext.aluFunc = aluFuncT'({2'b10, funcField[3], funcField[1]});
			end
			opLw: begin
				decNext.wrReg   = 1'b1;
				decNext.isLoad  = 1'b1;
				decNext.useImm  = 1'b1;
				decNext.aluFunc = fnAdd;
			end
			opSw: begin
				decNext.isStore = 1'b1;
				decNext.useImm  = 1'b1;
				decNext.aluFunc = fnAdd;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decEx <= '0;
		end else begin
			decEx <= decNext;
		end
	end

endmodule

//--- execute/forwardUnit.sv
// ------------------------------------------------
// Operand bypass for one source register.
// Memory stage wins over write-back.
// ------------------------------------------------
`timescale 1ns/1ps

module forwardUnit
	import cpuPkg::*;
(
	input  regIdxT          srcIdx,
	input  logic [xlen-1:0] regData,
	input  logic            memValid,
	input  logic            memWr,
	input  regIdxT          memIdx,
	input  logic [xlen-1:0] memData,
	input  retireT          wbIn,
	output logic [xlen-1:0] operand
);

	logic memHit;
	logic wbHit;

	assign memHit = memValid && memWr && (memIdx == srcIdx);
	assign wbHit  = wbIn.valid && wbIn.wrReg && (wbIn.rd == srcIdx);

	always_comb begin
		if (memHit) begin
			operand = memData;
		end else if (wbHit) begin
			operand = wbIn.data;
		end else begin
			operand = regData;
		end
	end

endmodule

//--- execute/alu.sv
// ------------------------------------------------
// Integer ALU. Compares are signed, result 0 or 1.
// Unlisted function codes give zero.
// ------------------------------------------------
`timescale 1ns/1ps

module alu
	import cpuPkg::*;
(
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  aluFuncT         func,
	output logic [xlen-1:0] result
);

	logic isEq;
	logic isLt;

	assign isEq = (a == b);
	assign isLt = ($signed(a) < $signed(b));

	always_comb begin
		case (func)
			fnAdd: result = a + b;
			fnSub: result = a - b;
			fnAnd: result = a & b;
			fnOr:  result = a | b;
			fnXor: result = a ^ b;
			// Compare flag in bit 0
			fnEq:  result = {{(xlen-1){1'b0}}, isEq};
			fnNe:  result = {{(xlen-1){1'b0}}, !isEq};
			fnLt:  result = {{(xlen-1){1'b0}}, isLt};
			fnGe:  result = {{(xlen-1){1'b0}}, !isLt};
			default: result = '0;
		endcase
	end

endmodule

//--- execute/executeStage.sv
// ------------------------------------------------
// Execute stage with two-source forwarding.
// exMemFwd is {valid, wrReg} of the memory stage.
// Loads and stores compute rs1 + imm.
// ------------------------------------------------
`timescale 1ns/1ps

module executeStage
	import cpuPkg::*;
(
	input  logic            clk,
	input  logic            rstN,
	input  decExT           decEx,
	input  logic [xlen-1:0] memResult,
	input  logic [1:0]      exMemFwd,
	input  retireT          wbIn,
	output exMemT           exMem
);

	logic [xlen-1:0] operandA;
	logic [xlen-1:0] rs2Fwd;
	logic [xlen-1:0] operandB;
	logic [xlen-1:0] aluResult;

	// Memory stage rd comes from our own output register
	forwardUnit fwdA (
		.srcIdx  (decEx.rs1),
		.regData (decEx.rs1Data),
		.memValid(exMemFwd[1]),
		.memWr   (exMemFwd[0]),
		.memIdx  (exMem.rd),
		.memData (memResult),
		.wbIn    (wbIn),
		.operand (operandA)
	);

	forwardUnit fwdB (
		.srcIdx  (decEx.rs2),
		.regData (decEx.rs2Data),
		.memValid(exMemFwd[1]),
		.memWr   (exMemFwd[0]),
		.memIdx  (exMem.rd),
		.memData (memResult),
		.wbIn    (wbIn),
		.operand (rs2Fwd)
	);

	assign operandB = decEx.useImm ? decEx.immediate : rs2Fwd;

	alu alu (
		.a     (operandA),
		.b     (operandB),
		.func  (decEx.aluFunc),
		.result(aluResult)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMem <= '0;
		end else begin
			exMem.valid     <= decEx.valid;
			exMem.wrReg     <= decEx.wrReg;
			exMem.isLoad    <= decEx.isLoad;
			exMem.isStore   <= decEx.isStore;
			exMem.rd        <= decEx.rd;
			exMem.aluResult <= aluResult;
			// Store data is the forwarded rd value
			exMem.storeData <= rs2Fwd;
		end
	end

endmodule

//--- src/memoryStage.sv
// ------------------------------------------------
// Data memory of 2**dmemAddrBits words.
// Word addressed, higher address bits wrap.
// Reads are combinational, writes on the clock.
// ------------------------------------------------
`timescale 1ns/1ps

module memoryStage
	import cpuPkg::*;
#(
	parameter int dmemAddrBits = 8
) (
	input  logic            clk,
	input  logic            rstN,
	input  exMemT           exMem,
	output logic [xlen-1:0] memResult,
	output retireT          retire
);

	localparam int memWords = 2 ** dmemAddrBits;

	logic [xlen-1:0]         dmem [memWords];
	logic [dmemAddrBits-1:0] wordAddr;

	// Byte address, drop the two low bits
	assign wordAddr = exMem.aluResult[dmemAddrBits+1:2];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < memWords; i++) begin
				dmem[i] <= '0;
			end
		end else if (exMem.valid && exMem.isStore) begin
			dmem[wordAddr] <= exMem.storeData;
		end
	end

	// Also feeds the one-ahead forward in execute
	assign memResult = exMem.isLoad ? dmem[wordAddr] : exMem.aluResult;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			retire <= '0;
		end else begin
			retire.valid <= exMem.valid;
			retire.wrReg <= exMem.valid && exMem.wrReg;
			retire.rd    <= exMem.rd;
			retire.data  <= memResult;
		end
	end

	loadStoreExclusive: assert property (@(posedge clk) disable iff (!rstN)
		exMem.valid |-> !(exMem.isLoad && exMem.isStore));

endmodule

//--- src/cpuTop.sv
// ------------------------------------------------
// Pipelined 32-bit integer core, no branches.
// One instruction per strobe, no back-pressure.
// Retire follows the strobe by four clock edges.
// ------------------------------------------------
`timescale 1ns/1ps

module cpuTop
	import cpuPkg::*;
#(
	parameter int dmemAddrBits = 8
) (
	input  logic   clk,
	input  logic   rstN,
	input  instInT instIn,
	output retireT retire
);

	decExT           decEx;
	exMemT           exMem;
	logic [xlen-1:0] memResult;

	// Fetch register, decode and register read
	decodeStage decodeStage (
		.clk   (clk),
		.rstN  (rstN),
		.instIn(instIn),
		.wbIn  (retire),
		.decEx (decEx)
	);

	// Forwarding sources are the memory stage and write-back
	executeStage executeStage (
		.clk      (clk),
		.rstN     (rstN),
		.decEx    (decEx),
		.memResult(memResult),
		.exMemFwd ({exMem.valid, exMem.wrReg}),
		.wbIn     (retire),
		.exMem    (exMem)
	);

	memoryStage #(
		.dmemAddrBits(dmemAddrBits)
	) memoryStage (
		.clk      (clk),
		.rstN     (rstN),
		.exMem    (exMem),
		.memResult(memResult),
		.retire   (retire)
	);

endmodule

//--- verification/cpuTb.sv
// ------------------------------------------------
// Trace-driven testbench for cpuTop.
// Run from the project root, reads the trace there.
// Retire data is compared only where wrReg is expected.
// ------------------------------------------------
`timescale 1ns/1ps

module cpuTb
	import cpuPkg::*;
();

	localparam int clkPeriod = 100;
	localparam int driveDelay = 10;
	localparam int resetCycles = 16;
	localparam int retireLatency = 4;
	localparam int jitterMax = 2;

	typedef struct packed {
		logic            wrReg;
		regIdxT          rd;
		logic [xlen-1:0] data;
		int              cycle;
	} expectT;

	logic   clk;
	logic   rstN;
	instInT instIn;
	retireT retire;

	// One record per section or instruction line of the trace
	bit              recIsTest[$];
	string           recName[$];
	int              recJitter[$];
	logic [xlen-1:0] recWord[$];
	int              recGap[$];
	logic            recWr[$];
	regIdxT          recRd[$];
	logic [xlen-1:0] recData[$];
	int              maxGap = 0;
	bit              traceLoaded = 1'b0;

	expectT expQ[$];
	int     cycleCount = 0;
	int     errorCount = 0;
	int     checkCount = 0;
	int     testCount = 0;
	int     testStartErrors = 0;
	int     testInstrs = 0;
	bit     jitterOn = 1'b0;
	bit     testOpen = 1'b0;
	string  testName = "";

	cpuTop #(
		.dmemAddrBits(8)
	) dut (
		.clk   (clk),
		.rstN  (rstN),
		.instIn(instIn),
		.retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	task automatic loadTrace();
		int              fd;
		string           line;
		string           name;
		int              jitter;
		logic [xlen-1:0] word;
		int              gap;
		int              wr;
		regIdxT          rd;
		logic [xlen-1:0] data;
		fd = $fopen("verification/cpuTrace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file verification/cpuTrace.txt");
			errorCount++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() <= 1 || line.getc(0) == "#") begin
				continue;
			end
			if ($sscanf(line, "test %s %d", name, jitter) == 2) begin
				recIsTest.push_back(1'b1);
				recName.push_back(name);
				recJitter.push_back(jitter);
				recWord.push_back('0);
				recGap.push_back(0);
				recWr.push_back(1'b0);
				recRd.push_back('0);
				recData.push_back('0);
			end else if ($sscanf(line, "%h %d %d %h %h", word, gap, wr, rd, data) == 5) begin
				recIsTest.push_back(1'b0);
				recName.push_back("");
				recJitter.push_back(0);
				recWord.push_back(word);
				recGap.push_back(gap);
				recWr.push_back(wr != 0);
				recRd.push_back(rd);
				recData.push_back(data);
				if (gap > maxGap) begin
					maxGap = gap;
				end
			end else begin
				$display("Trace line could not be read: %s", line);
				errorCount++;
			end
		end
		$fclose(fd);
	endtask

	task automatic checkIdleAfterReset();
		repeat (6) begin
			@(negedge clk);
			checkCount++;
			if (retire.valid !== 1'b0) begin
				$display("CHECK FAILED retire.valid after reset: expected 0, got %h",
					retire.valid);
				errorCount++;
			end
		end
		testCount++;
		$display("Test idle_after_reset finished: 0 instructions, %0d errors", errorCount);
	endtask

	// Leaves the driver just after a rising edge
	task automatic startTest(input int idx);
		testName = recName[idx];
		jitterOn = (recJitter[idx] != 0);
		testStartErrors = errorCount;
		testInstrs = 0;
		testOpen = 1'b1;
		@(posedge clk);
		#(driveDelay);
	endtask

	task automatic finishTest();
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		testCount++;
		testOpen = 1'b0;
		$display("Test %s finished: %0d instructions, %0d errors",
			testName, testInstrs, errorCount - testStartErrors);
	endtask

	// Sampled at the next edge, retires after edge sample+3
	task automatic issueInstruction(input int idx);
		expectT entry;
		int     idle;
		entry.wrReg = recWr[idx];
		entry.rd = recRd[idx];
		entry.data = recData[idx];
		entry.cycle = cycleCount + retireLatency;
		expQ.push_back(entry);
		instIn.valid = 1'b1;
		instIn.word = recWord[idx];
		testInstrs++;
		idle = recGap[idx];
		if (jitterOn) begin
			idle = idle + int'($urandom % (jitterMax + 1));
		end
		@(posedge clk);
		#(driveDelay);
		instIn = '0;
		repeat (idle) begin
			@(posedge clk);
			#(driveDelay);
		end
	endtask

	// In-order retire checker, sampled away from the clock edge
	always @(negedge clk) begin
		expectT exp;
		if (rstN && retire.valid) begin
			if (expQ.size() == 0) begin
				$display("Instruction retired with nothing outstanding, rd %h", retire.rd);
				errorCount++;
			end else begin
				exp = expQ.pop_front();
				checkCount += 3;
				if (cycleCount != exp.cycle) begin
					$display("CHECK FAILED retire.valid cycle in %s: expected %h, got %h",
						testName, exp.cycle, cycleCount);
					errorCount++;
				end
				if (retire.wrReg !== exp.wrReg) begin
					$display("CHECK FAILED retire.wrReg in %s: expected %h, got %h",
						testName, exp.wrReg, retire.wrReg);
					errorCount++;
				end
				if (retire.rd !== exp.rd) begin
					$display("CHECK FAILED retire.rd in %s: expected %h, got %h",
						testName, exp.rd, retire.rd);
					errorCount++;
				end
				if (exp.wrReg) begin
					checkCount++;
					if (retire.data !== exp.data) begin
						$display("CHECK FAILED retire.data in %s: expected %h, got %h",
							testName, exp.data, retire.data);
						errorCount++;
					end
				end
			end
		end
	end

	initial begin
		instIn = '0;
		rstN = 1'b0;
		void'($urandom(32'hb4a3_fa53));
		loadTrace();
		traceLoaded = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#(driveDelay);
		rstN = 1'b1;
		checkIdleAfterReset();
		for (int idx = 0; idx < recIsTest.size(); idx++) begin
			if (recIsTest[idx]) begin
				if (testOpen) begin
					finishTest();
				end
				startTest(idx);
			end else begin
				issueInstruction(idx);
			end
		end
		if (testOpen) begin
			finishTest();
		end
		// Catch any late or extra retire
		repeat (8) @(posedge clk);
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Each trace line may take its gap, the jitter, the issue cycle and a drain
	initial begin
		int limitCycles;
		while (!traceLoaded) @(posedge clk);
		limitCycles = resetCycles + 32 + recIsTest.size() * (maxGap + jitterMax + 1 + 8);
		repeat (limitCycles) @(posedge clk);
		$display("Timeout: not every instruction retired within %0d cycles", limitCycles);
		$display("Something failed");
		$finish;
	end

endmodule

//--- verification/cpuTrace.txt
# Section line: test <name> <jitter>, jitter 1 adds random idle cycles
# Instruction line: <word> <idle cycles> <wrReg> <rd> <data>, hex word, rd and data
# data is ignored when wrReg is 0
test first_reads 0
C5123000 0 1 1 00000000
C6FED000 0 1 F 00000000
D1045000 0 1 0 00000001
C0987000 0 1 9 00000000
306A0010 0 1 6 00000000
test alu_forward 0
40120064 0 1 1 00000064
4021FFFF 0 1 2 00000063
C0312000 0 1 3 000000C7
C1413000 0 1 4 FFFFFF9D
C4542000 0 1 5 00000001
C5654000 0 1 6 FFFFFF9D
C6761000 0 1 7 FFFFFFF9
468700FF 0 1 8 FFFFFF06
40988000 0 1 9 FFFF7F06
C0111000 0 1 1 000000C8
C0111000 0 1 1 00000190
C0D18000 0 1 D 00000096
test compare 0
D2A45000 0 1 A 00000001
D2B54000 0 1 B 00000000
DAC45000 0 1 C 00000000
DAEA0000 0 1 E 00000001
D1F46000 0 1 F 00000001
D9A46000 0 1 A 00000000
D1BAC000 0 1 B 00000001
D2C71000 0 1 C 00000001
test memory 0
70820020 0 0 8 00000000
30120020 0 1 1 FFFFFF06
C0315000 0 1 3 FFFFFF07
30420420 0 1 4 FFFFFF06
703007F0 0 0 3 00000000
3050FFF0 0 1 5 FFFFFF07
705C0000 0 0 5 00000000
306E0000 0 1 6 FFFFFF07
307A0100 0 1 7 00000000
test retire_order 1
00920000 2 0 9 00000000
40990001 0 1 9 FFFF7F07
F5A12345 1 0 A 00000000
C0BA0000 3 1 B 00000001
70B00008 0 0 B 00000000
30C00008 5 1 C 00000001
80000000 0 0 0 00000000
test random_gaps 1
401C0010 0 1 1 00000011
70110040 0 0 1 00000000
30210040 0 1 2 00000011
C0321000 0 1 3 00000022
DA432000 0 1 4 00000001
C1543000 0 1 5 FFFFFFDF

//--- sim.f
common/cpuPkg.sv
src/registerFile.sv
src/decodeStage.sv
execute/forwardUnit.sv
execute/alu.sv
execute/executeStage.sv
src/memoryStage.sv
src/cpuTop.sv
verification/cpuTb.sv

//--- run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f sim.f --top-module cpuTb \
	-Mdir "$buildDir" -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/cpuSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "Everything OK" "$logFile"; then
	exit 0
fi
exit 1
